// File: counter_defines.svh
// ####################################################################
// Build-wide constants of the photon counter. Include where needed,
// the include guard keeps repeated inclusion harmless
// ####################################################################
`ifndef COUNTER_DEFINES_SVH
`define COUNTER_DEFINES_SVH

`define CNT_CHANNELS     2
`define CNT_INPUTS       4
`define CNT_BIN_DEPTH    4096
`define CNT_BIN_AW       12

// Register reset defaults
`define CNT_TIMEOUT_RST  125

// Bus address map
`define CNT_RAM_BASE     32'h0001_0000
`define CNT_RAM_STRIDE   32'h0000_4000
`define CNT_REG_LAST     32'h0000_0024

// Cycles from the first req edge to ack
`define CNT_REG_LAT      2
`define CNT_MEM_LAT      3

`endif

// File: counter_pkg.sv
// ####################################################################
// Shared types of the photon counter, imported by every block
// ####################################################################
`include "counter_defines.svh"

package counter_pkg;

   typedef logic [31:0]                word_t;
   typedef logic [`CNT_BIN_AW-1:0]     bin_addr_t;
   typedef logic [`CNT_INPUTS-1:0]     in_vec_t;

   typedef struct packed {
      word_t [`CNT_CHANNELS-1:0] cnt;  // Index 0 is channel 1
   } bin_counts_t;

   // Same bit order as register 0x1C
   typedef struct packed {
      logic    polarity;
      in_vec_t invert;
      in_vec_t mask;
   } trig_cfg_t;

   typedef enum logic [2:0] {
      CMD_NONE            = 3'd0,
      CMD_GO_IDLE         = 3'd1,
      CMD_RESET           = 3'd2,
      CMD_COUNT_IMMEDIATE = 3'd3,
      CMD_COUNT_TRIGGERED = 3'd4,
      CMD_SW_TRIGGER      = 3'd5
   } cnt_cmd_e;

   typedef enum logic [3:0] {
      ST_IDLE         = 4'd0,
      ST_IMM_START    = 4'd1,
      ST_IMM_WAIT     = 4'd2,
      ST_TRIG_WAIT    = 4'd3,
      ST_STORE        = 4'd4,
      ST_PREDELAY     = 4'd5,
      ST_PRESTORE     = 4'd6,
      ST_TRIG_TIMEOUT = 4'd7
   } seq_state_e;

   typedef struct packed {
      logic  req;
      logic  we;
      word_t addr;
      word_t wdata;
   } bus_req_t;

   typedef struct packed {
      logic  ack;
      word_t rdata;
   } bus_rsp_t;

   typedef struct packed {
      word_t     timeout;    // Window length minus one
      word_t     predelay;
      bin_addr_t max_bin;    // Last bin before wrap
   } seq_cfg_t;

endpackage

// File: input_conditioner.sv
// ####################################################################
// Brings the external pins into the clock domain and evaluates the
// trigger condition on the synchronized copy
// ####################################################################
`timescale 1ns/1ps

module input_conditioner (
   input  logic                   i_clk,
   input  logic                   i_rstn,
   input  counter_pkg::in_vec_t   i_pins,
   input  counter_pkg::trig_cfg_t i_cfg,
   output counter_pkg::in_vec_t   o_sync,
   output logic                   o_trigger
);
   import counter_pkg::*;

   in_vec_t meta1;
   in_vec_t meta2;
   logic    trig_cond;

   // Three flop chain
   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         meta1  <= '0;
         meta2  <= '0;
         o_sync <= '0;
      end else begin
         meta1  <= i_pins;
         meta2  <= meta1;
         o_sync <= meta2;
      end
   end

   // All masked inputs active, then compared against polarity
   assign trig_cond = ((((o_sync ^ i_cfg.invert) & i_cfg.mask) == i_cfg.mask)
                       == i_cfg.polarity);

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_trigger <= 1'b0;
      end else begin
         o_trigger <= trig_cond;
      end
   end

   // Coming out of reset no stale trigger and clean sync chain
   a_trig_reset: assert property (@(posedge i_clk)
      !i_rstn |=> (!o_trigger && o_sync == '0));

endmodule

// File: pulse_counter_bank.sv
// ####################################################################
// Rising edge counters for the counting channels. Counts only while
// the window is enabled and clears itself outside the window
// ####################################################################
`timescale 1ns/1ps
`include "counter_defines.svh"

module pulse_counter_bank (
   input  logic                     i_clk,
   input  logic                     i_rstn,
   input  counter_pkg::in_vec_t     i_sync,
   input  logic                     i_enable,
   output counter_pkg::bin_counts_t o_counts
);
   import counter_pkg::*;

   logic [`CNT_CHANNELS-1:0] prev;   // Previous sample per channel

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         prev     <= '0;
         o_counts <= '0;
      end else begin
         prev <= i_sync[`CNT_CHANNELS-1:0];
         for (int c = 0; c < `CNT_CHANNELS; c++) begin
            if (!i_enable) begin
               o_counts.cnt[c] <= '0;
            end else if (i_sync[c] && !prev[c]) begin
               o_counts.cnt[c] <= o_counts.cnt[c] + word_t'(1);   // Wraps at 2^32
            end
         end
      end
   end

endmodule

// File: count_sequencer.sv
// ####################################################################
// Counting FSM. Times the windows, latches the last results and
// writes one bin per trigger into the bin memories
// ####################################################################
`timescale 1ns/1ps

module count_sequencer (
   input  logic                     i_clk,
   input  logic                     i_rstn,
   input  logic                     i_cmd_valid,
   input  counter_pkg::cnt_cmd_e    i_cmd,
   input  counter_pkg::seq_cfg_t    i_cfg,
   input  logic                     i_trigger,
   input  counter_pkg::bin_counts_t i_counts,
   output logic                     o_enable,
   output counter_pkg::seq_state_e  o_state,
   output counter_pkg::bin_counts_t o_last_counts,
   output counter_pkg::bin_addr_t   o_bin,
   output logic                     o_wr,
   output counter_pkg::bin_counts_t o_wr_counts,
   output counter_pkg::word_t       o_wr_dur
);
   import counter_pkg::*;

   word_t clk_cnt;    // Down counter for predelay and window
   word_t dur;        // Length of the current window
   logic  take_cmd;   // Mode commands preempt any state
   logic  fire;

   assign take_cmd = i_cmd_valid && (i_cmd inside {CMD_GO_IDLE, CMD_RESET,
                                                   CMD_COUNT_IMMEDIATE, CMD_COUNT_TRIGGERED});
   assign fire     = i_trigger || (i_cmd_valid && i_cmd == CMD_SW_TRIGGER);

   assign o_enable    = (o_state == ST_IMM_WAIT) || (o_state == ST_TRIG_TIMEOUT);
   assign o_wr        = (o_state == ST_PRESTORE);
   assign o_wr_counts = o_last_counts;
   assign o_wr_dur    = dur;

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_state       <= ST_IDLE;
         clk_cnt       <= '0;
         dur           <= '0;
         o_last_counts <= '0;
         o_bin         <= '0;
      end else if (take_cmd) begin
         case (i_cmd)
            CMD_COUNT_IMMEDIATE: o_state <= ST_IMM_START;
            CMD_COUNT_TRIGGERED: o_state <= ST_TRIG_WAIT;
            CMD_RESET: begin
               o_state       <= ST_IDLE;
               o_bin         <= '0;
               o_last_counts <= '0;
            end
            default: o_state <= ST_IDLE;   // go_idle
         endcase
      end else begin
         case (o_state)
            ST_IDLE: ;
            ST_IMM_START: begin
               clk_cnt <= i_cfg.timeout;
               dur     <= i_cfg.timeout;
               o_state <= ST_IMM_WAIT;
            end
            ST_IMM_WAIT: begin
               if (clk_cnt == '0) begin
                  o_last_counts <= i_counts;
                  o_state       <= ST_IDLE;
               end else begin
                  clk_cnt <= clk_cnt - word_t'(1);
               end
            end
            ST_TRIG_WAIT: begin
               if (fire && i_cfg.predelay != '0) begin
                  clk_cnt <= i_cfg.predelay;
                  o_state <= ST_PREDELAY;
               end else if (fire) begin
                  clk_cnt <= i_cfg.timeout;
                  dur     <= i_cfg.timeout;
                  o_state <= ST_TRIG_TIMEOUT;
               end
            end
            ST_PREDELAY: begin
               if (clk_cnt == '0) begin
                  clk_cnt <= i_cfg.timeout;
                  dur     <= i_cfg.timeout;
                  o_state <= ST_TRIG_TIMEOUT;
               end else begin
                  clk_cnt <= clk_cnt - word_t'(1);
               end
            end
            ST_TRIG_TIMEOUT: begin
               if (clk_cnt == '0) begin
                  o_last_counts <= i_counts;
                  o_state       <= ST_PRESTORE;
               end else begin
                  clk_cnt <= clk_cnt - word_t'(1);
               end
            end
            ST_PRESTORE: o_state <= ST_STORE;   // Memory write happens here
            ST_STORE: begin
               // Also recovers if max_bin was lowered below the current bin
               o_bin   <= (o_bin >= i_cfg.max_bin) ? '0 : o_bin + bin_addr_t'(1);
               o_state <= ST_TRIG_WAIT;
            end
            default: o_state <= ST_IDLE;
         endcase
      end
   end

   a_bin_range: assert property (@(posedge i_clk) disable iff (!i_rstn)
      (o_state == ST_STORE && !take_cmd) |=> (o_bin <= i_cfg.max_bin));

   a_wr_pulse: assert property (@(posedge i_clk) disable iff (!i_rstn)
      $rose(o_wr) |=> !o_wr);

endmodule

// File: bin_ram.sv
// ####################################################################
// Dual port bin memory. Port A takes the sequencer writes, port B
// serves the bus with a registered read
// ####################################################################
`timescale 1ns/1ps
`include "counter_defines.svh"

module bin_ram #(
   parameter type payload_t = counter_pkg::word_t
) (
   input  logic                   i_clk,
   input  counter_pkg::bin_addr_t i_addr_a,
   input  logic                   i_we_a,
   input  payload_t               i_data_a,
   input  counter_pkg::bin_addr_t i_addr_b,
   input  logic                   i_we_b,
   input  payload_t               i_data_b,
   output payload_t               o_data_b
);

   payload_t mem [`CNT_BIN_DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_we_a) begin
         mem[i_addr_a] <= i_data_a;
      end
      if (i_we_b) begin
         mem[i_addr_b] <= i_data_b;   // Bus wins on a same-bin collision
      end
      o_data_b <= mem[i_addr_b];      // Read before write
   end

endmodule

// File: counter_regs.sv
// ####################################################################
// Four-phase bus slave. Holds the configuration registers, issues
// commands to the sequencer and gives the bus access to the bin memories
// ####################################################################
`timescale 1ns/1ps
`include "counter_defines.svh"

module counter_regs (
   input  logic                     i_clk,
   input  logic                     i_rstn,
   input  counter_pkg::bus_req_t    i_bus,
   output counter_pkg::bus_rsp_t    o_bus,
   output logic                     o_cmd_valid,
   output counter_pkg::cnt_cmd_e    o_cmd,
   output counter_pkg::seq_cfg_t    o_seq_cfg,
   output counter_pkg::trig_cfg_t   o_trig_cfg,
   input  counter_pkg::seq_state_e  i_state,
   input  counter_pkg::bin_counts_t i_last_counts,
   input  counter_pkg::bin_addr_t   i_bin,
   output counter_pkg::bin_addr_t   o_ram_addr,
   output logic                     o_cnt_we,
   output counter_pkg::bin_counts_t o_cnt_wdata,
   input  counter_pkg::bin_counts_t i_cnt_rdata,
   output logic                     o_dur_we,
   output counter_pkg::word_t       o_dur_wdata,
   input  counter_pkg::word_t       i_dur_rdata
);
   import counter_pkg::*;

   word_t      ram_off;    // Offset into the memory windows
   logic [1:0] win;        // 0 ch1, 1 ch2, 2 durations
   logic       in_ram;
   logic       in_cnt;
   logic       busy;       // Transfer accepted, ack pending or held
   logic [1:0] wait_cnt;
   logic       rmw_cycle;  // Single port B write slot
   word_t      rd_data;

   assign ram_off = i_bus.addr - `CNT_RAM_BASE;
   assign win     = 2'(ram_off / `CNT_RAM_STRIDE);
   assign in_ram  = (i_bus.addr >= `CNT_RAM_BASE)
                    && (ram_off < (`CNT_CHANNELS + 1) * `CNT_RAM_STRIDE);
   assign in_cnt  = in_ram && (win < `CNT_CHANNELS);

   assign o_ram_addr = ram_off[`CNT_BIN_AW+1:2];   // One bin per word

   // Read data of the bin is back one cycle after req, write in the middle cycle
   assign rmw_cycle   = busy && !o_bus.ack && (wait_cnt == 2'd1) && in_ram && i_bus.we;
   assign o_cnt_we    = rmw_cycle && in_cnt;
   assign o_dur_we    = rmw_cycle && !in_cnt;
   assign o_dur_wdata = i_bus.wdata;

   // Keep the other channel's word
   always_comb begin
      o_cnt_wdata                = i_cnt_rdata;
      o_cnt_wdata.cnt[win[0]]    = i_bus.wdata;
   end

   always_comb begin
      rd_data = '0;
      if (in_ram) begin
         rd_data = in_cnt ? i_cnt_rdata.cnt[win[0]] : i_dur_rdata;
      end else if (i_bus.addr <= `CNT_REG_LAST) begin
         case (i_bus.addr[5:0])
            6'h00:   rd_data = 32'(i_state);
            6'h04:   rd_data = o_seq_cfg.timeout;
            6'h08:   rd_data = i_last_counts.cnt[0];
            6'h0C:   rd_data = i_last_counts.cnt[1];
            6'h10:   rd_data = 32'(o_seq_cfg.max_bin);
            6'h18:   rd_data = o_seq_cfg.predelay;
            6'h1C:   rd_data = 32'(o_trig_cfg);
            6'h20:   rd_data = 32'(i_bin);
            default: rd_data = '0;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_bus       <= '0;
         busy        <= 1'b0;
         wait_cnt    <= '0;
         o_cmd_valid <= 1'b0;
         o_cmd       <= CMD_NONE;
         o_seq_cfg   <= '{timeout: `CNT_TIMEOUT_RST, predelay: '0,
                          max_bin: bin_addr_t'(`CNT_BIN_DEPTH - 1)};
         o_trig_cfg  <= '{polarity: 1'b1, invert: '0, mask: '0};
      end else begin
         o_cmd_valid <= 1'b0;
         if (!busy) begin
            busy     <= i_bus.req;
            wait_cnt <= in_ram ? 2'(`CNT_MEM_LAT - 1) : 2'(`CNT_REG_LAT - 1);
         end else if (o_bus.ack) begin
            if (!i_bus.req) begin   // Host done, release
               o_bus.ack <= 1'b0;
               busy      <= 1'b0;
            end
         end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
         end else begin
            o_bus.ack   <= 1'b1;
            o_bus.rdata <= rd_data;
            if (i_bus.we && !in_ram) begin
               case (i_bus.addr)
                  32'h00: begin
                     o_cmd_valid <= 1'b1;
                     if (i_bus.wdata <= 32'(CMD_SW_TRIGGER)) begin
                        o_cmd <= cnt_cmd_e'(i_bus.wdata[2:0]);
                     end else begin
                        o_cmd <= CMD_NONE;   // Unknown codes do nothing
                     end
                  end
                  32'h04:  o_seq_cfg.timeout  <= i_bus.wdata;
                  32'h10:  o_seq_cfg.max_bin  <= i_bus.wdata[`CNT_BIN_AW-1:0];
                  32'h18:  o_seq_cfg.predelay <= i_bus.wdata;
                  32'h1C:  o_trig_cfg         <= trig_cfg_t'(i_bus.wdata[8:0]);
                  default: ;
               endcase
            end
         end
      end
   end

   a_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rstn)
      $rose(o_bus.ack) |-> $past(i_bus.req));

endmodule

// File: photon_counter_top.sv
// ####################################################################
// Two channel photon counter on the register bus. Connects input
// conditioning, counters, sequencer, bin memories and registers
// ####################################################################
`timescale 1ns/1ps

module photon_counter_top (
   input  logic                  i_clk,
   input  logic                  i_rstn,
   input  counter_pkg::in_vec_t  i_pins,
   input  counter_pkg::bus_req_t i_bus,
   output counter_pkg::bus_rsp_t o_bus
);
   import counter_pkg::*;

   in_vec_t     sync;
   logic        trigger;
   logic        enable;
   trig_cfg_t   trig_cfg;
   seq_cfg_t    seq_cfg;
   logic        cmd_valid;
   cnt_cmd_e    cmd;
   seq_state_e  state;
   bin_counts_t counts;
   bin_counts_t last_counts;
   bin_addr_t   bin;
   logic        wr;
   bin_counts_t wr_counts;
   word_t       wr_dur;
   bin_addr_t   ram_addr;     // Bus side bin index
   logic        cnt_we;
   bin_counts_t cnt_wdata;
   bin_counts_t cnt_rdata;
   logic        dur_we;
   word_t       dur_wdata;
   word_t       dur_rdata;

   input_conditioner u_cond (
      .i_clk     (i_clk),
      .i_rstn    (i_rstn),
      .i_pins    (i_pins),
      .i_cfg     (trig_cfg),
      .o_sync    (sync),
      .o_trigger (trigger)
   );

   pulse_counter_bank u_counters (
      .i_clk    (i_clk),
      .i_rstn   (i_rstn),
      .i_sync   (sync),
      .i_enable (enable),
      .o_counts (counts)
   );

   count_sequencer u_seq (
      .i_clk         (i_clk),
      .i_rstn        (i_rstn),
      .i_cmd_valid   (cmd_valid),
      .i_cmd         (cmd),
      .i_cfg         (seq_cfg),
      .i_trigger     (trigger),
      .i_counts      (counts),
      .o_enable      (enable),
      .o_state       (state),
      .o_last_counts (last_counts),
      .o_bin         (bin),
      .o_wr          (wr),
      .o_wr_counts   (wr_counts),
      .o_wr_dur      (wr_dur)
   );

   bin_ram #(.payload_t(bin_counts_t)) u_cnt_ram (
      .i_clk    (i_clk),
      .i_addr_a (bin),
      .i_we_a   (wr),
      .i_data_a (wr_counts),
      .i_addr_b (ram_addr),
      .i_we_b   (cnt_we),
      .i_data_b (cnt_wdata),
      .o_data_b (cnt_rdata)
   );

   bin_ram #(.payload_t(word_t)) u_dur_ram (
      .i_clk    (i_clk),
      .i_addr_a (bin),
      .i_we_a   (wr),
      .i_data_a (wr_dur),
      .i_addr_b (ram_addr),
      .i_we_b   (dur_we),
      .i_data_b (dur_wdata),
      .o_data_b (dur_rdata)
   );

   counter_regs u_regs (
      .i_clk         (i_clk),
      .i_rstn        (i_rstn),
      .i_bus         (i_bus),
      .o_bus         (o_bus),
      .o_cmd_valid   (cmd_valid),
      .o_cmd         (cmd),
      .o_seq_cfg     (seq_cfg),
      .o_trig_cfg    (trig_cfg),
      .i_state       (state),
      .i_last_counts (last_counts),
      .i_bin         (bin),
      .o_ram_addr    (ram_addr),
      .o_cnt_we      (cnt_we),
      .o_cnt_wdata   (cnt_wdata),
      .i_cnt_rdata   (cnt_rdata),
      .o_dur_we      (dur_we),
      .o_dur_wdata   (dur_wdata),
      .i_dur_rdata   (dur_rdata)
   );

endmodule

// File: tb_photon_counter.sv
// ####################################################################
// Directed testbench for the photon counter top level. Drives the bus
// and the input pins, then checks registers and bin memories
// ####################################################################
`timescale 1ns/1ps
`include "counter_defines.svh"

module tb_photon_counter;
   import counter_pkg::*;

   localparam int    ACK_LIMIT  = 40;    // Cycles allowed per handshake phase
   localparam int    POLL_LIMIT = 400;
   localparam word_t CH1_BASE   = `CNT_RAM_BASE;
   localparam word_t CH2_BASE   = `CNT_RAM_BASE + `CNT_RAM_STRIDE;
   localparam word_t DUR_BASE   = `CNT_RAM_BASE + 2 * `CNT_RAM_STRIDE;

   logic     clk;
   logic     rstn;
   in_vec_t  pins;
   bus_req_t bus_req;
   bus_rsp_t bus_rsp;

   int    checks;
   int    mismatches;
   int    failures;
   word_t lfsr;

   photon_counter_top DUT (
      .i_clk  (clk),
      .i_rstn (rstn),
      .i_pins (pins),
      .i_bus  (bus_req),
      .o_bus  (bus_rsp)
   );

   always #20 clk = ~clk;   // 40 ns period

   task automatic finish_run();
      $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   endtask

   task automatic abort_run(input string why);
      failures++;
      $display("ERROR: %s", why);
      finish_run();
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic word_t lfsr_step(input word_t s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic pick_count(output int n);
      logic [4:0] v;
      v = '0;
      for (int i = 0; i < 5; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[3:0], lfsr[0]};
      end
      n = int'(v) % 20 + 1;   // 1 to 20 pulses
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      checks++;
      if (act !== exp) begin
         mismatches++;
         $display("MISMATCH %s: expected 0x%08h actual 0x%08h", name, exp, act);
      end
   endtask

   task automatic check_state(input string name, input seq_state_e exp, input seq_state_e act);
      checks++;
      if (act !== exp) begin
         mismatches++;
         $display("MISMATCH %s: expected %0d (%s) actual %0d (%s)",
                  name, exp, exp.name(), act, act.name());
      end
   endtask

   task automatic check_bin(input string name, input bin_addr_t exp, input bin_addr_t act);
      checks++;
      if (act !== exp) begin
         mismatches++;
         $display("MISMATCH %s: expected %0d actual %0d", name, exp, act);
      end
   endtask

   // Sampled on the falling edge, away from the DUT's updates
   task automatic wait_ack(input logic level, input string what);
      int n;
      n = 0;
      @(negedge clk);
      while (bus_rsp.ack !== level && n < ACK_LIMIT) begin
         n++;
         @(negedge clk);
      end
      if (bus_rsp.ack !== level) begin
         abort_run($sformatf("ack did not go to %0b during %s", level, what));
      end
   endtask

   task automatic bus_write(input word_t addr, input word_t data);
      @(posedge clk);
      bus_req <= '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
      wait_ack(1'b1, $sformatf("write to 0x%0h", addr));
      @(posedge clk);
      bus_req.req <= 1'b0;
      wait_ack(1'b0, $sformatf("write to 0x%0h", addr));
   endtask

   task automatic bus_read(input word_t addr, output word_t data);
      @(posedge clk);
      bus_req <= '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
      wait_ack(1'b1, $sformatf("read of 0x%0h", addr));
      data = bus_rsp.rdata;   // Valid while ack is high
      @(posedge clk);
      bus_req.req <= 1'b0;
      wait_ack(1'b0, $sformatf("read of 0x%0h", addr));
   endtask

   // One cycle high, three low per pulse
   task automatic pulse_train(input int pin, input int count);
      repeat (count) begin
         @(posedge clk);
         pins[pin] <= 1'b1;
         @(posedge clk);
         pins[pin] <= 1'b0;
         repeat (2) @(posedge clk);
      end
   endtask

   task automatic wait_state(input seq_state_e exp, input string name);
      word_t rd;
      int    polls;
      polls = 0;
      bus_read(32'h00, rd);
      while (seq_state_e'(rd[3:0]) != exp && polls < POLL_LIMIT) begin
         polls++;
         bus_read(32'h00, rd);
      end
      if (seq_state_e'(rd[3:0]) != exp) begin
         abort_run($sformatf("%s: sequencer never reached state %0d", name, exp));
      end
   endtask

   task automatic test_reset_defaults();
      word_t rd;
      bus_read(32'h04, rd);
      check_word("defaults timeout", 32'd125, rd);
      bus_read(32'h10, rd);
      check_word("defaults max_bin", 32'd4095, rd);
      bus_read(32'h18, rd);
      check_word("defaults predelay", 32'd0, rd);
      bus_read(32'h1C, rd);
      check_word("defaults trigger config", 32'h100, rd);   // Polarity only
      bus_read(32'h00, rd);
      check_state("defaults state", ST_IDLE, seq_state_e'(rd[3:0]));
      bus_read(32'h20, rd);
      check_bin("defaults bin", bin_addr_t'(0), bin_addr_t'(rd[11:0]));
      bus_write(32'h18, 32'd77);
      bus_read(32'h18, rd);
      check_word("readback predelay", 32'd77, rd);
      bus_write(32'h1C, 32'h0A5);
      bus_read(32'h1C, rd);
      check_word("readback trigger config", 32'h0A5, rd);
      bus_write(32'h04, 32'd1000);
      bus_read(32'h04, rd);
      check_word("readback timeout", 32'd1000, rd);
   endtask

   task automatic test_immediate();
      int    n;
      int    m;
      word_t rd;
      pick_count(n);
      pick_count(m);
      bus_write(32'h04, 32'd400);
      bus_write(32'h00, 32'(CMD_COUNT_IMMEDIATE));
      repeat (10) @(posedge clk);
      pulse_train(0, n);
      pulse_train(1, m);
      wait_state(ST_IDLE, "immediate");
      bus_read(32'h08, rd);
      check_word("immediate ch1 count", word_t'(n), rd);
      bus_read(32'h0C, rd);
      check_word("immediate ch2 count", word_t'(m), rd);
   endtask

   task automatic test_triggered();
      int    n;
      int    m;
      word_t rd;
      pick_count(n);
      pick_count(m);
      bus_write(32'h18, 32'd50);
      bus_write(32'h04, 32'd300);
      bus_write(32'h1C, 32'h108);   // Pin 3 high fires
      bus_write(32'h00, 32'(CMD_COUNT_TRIGGERED));
      pulse_train(3, 1);
      bus_read(32'h00, rd);         // Trigger seen, predelay still running
      check_state("triggered predelay", ST_PREDELAY, seq_state_e'(rd[3:0]));
      repeat (70) @(posedge clk);   // Past sync, trigger and predelay
      pulse_train(0, n);
      pulse_train(1, m);
      wait_state(ST_TRIG_WAIT, "triggered");
      bus_read(CH1_BASE, rd);
      check_word("triggered bin 0 ch1", word_t'(n), rd);
      bus_read(CH2_BASE, rd);
      check_word("triggered bin 0 ch2", word_t'(m), rd);
      bus_read(DUR_BASE, rd);
      check_word("triggered bin 0 duration", 32'd300, rd);
      bus_read(32'h20, rd);
      check_bin("triggered bin", bin_addr_t'(1), bin_addr_t'(rd[11:0]));
   endtask

   task automatic test_bin_wrap();
      int    k[3];
      word_t rd;
      bus_write(32'h00, 32'(CMD_RESET));   // Start from bin 0
      bus_write(32'h10, 32'd1);
      bus_write(32'h18, 32'd0);
      bus_write(32'h04, 32'd200);
      bus_write(32'h00, 32'(CMD_COUNT_TRIGGERED));
      wait_state(ST_TRIG_WAIT, "wrap armed");
      for (int i = 0; i < 3; i++) begin
         pick_count(k[i]);
         bus_write(32'h00, 32'(CMD_SW_TRIGGER));
         repeat (10) @(posedge clk);
         pulse_train(0, k[i]);
         wait_state(ST_TRIG_WAIT, $sformatf("wrap trigger %0d", i));
      end
      bus_read(CH1_BASE, rd);
      check_word("wrap bin 0 ch1", word_t'(k[2]), rd);
      bus_read(CH1_BASE + 32'h4, rd);
      check_word("wrap bin 1 ch1", word_t'(k[1]), rd);
      bus_read(DUR_BASE + 32'h4, rd);
      check_word("wrap bin 1 duration", 32'd200, rd);
      bus_read(32'h20, rd);
      check_bin("wrap bin", bin_addr_t'(1), bin_addr_t'(rd[11:0]));
   endtask

   task automatic test_memory_and_reset();
      word_t rd;
      bus_write(CH1_BASE + 32'h10, 32'h1234_5678);
      bus_write(CH2_BASE + 32'h10, 32'hCAFE_0042);
      bus_read(CH2_BASE + 32'h10, rd);
      check_word("memory ch2 readback", 32'hCAFE_0042, rd);
      bus_read(CH1_BASE + 32'h10, rd);
      check_word("memory ch1 kept", 32'h1234_5678, rd);
      bus_read(32'h14, rd);
      check_word("unmapped register gap", 32'd0, rd);
      bus_read(`CNT_RAM_BASE + 3 * `CNT_RAM_STRIDE, rd);
      check_word("unmapped memory window", 32'd0, rd);
      bus_write(32'h00, 32'(CMD_RESET));
      bus_read(32'h20, rd);
      check_bin("reset bin", bin_addr_t'(0), bin_addr_t'(rd[11:0]));
      bus_read(32'h08, rd);
      check_word("reset ch1 last count", 32'd0, rd);
      bus_read(32'h0C, rd);
      check_word("reset ch2 last count", 32'd0, rd);
      bus_read(32'h00, rd);
      check_state("reset state", ST_IDLE, seq_state_e'(rd[3:0]));
   endtask

   initial begin
      clk        = 1'b0;
      rstn       = 1'b0;
      pins       = '0;
      bus_req    = '0;
      checks     = 0;
      mismatches = 0;
      failures   = 0;
      lfsr       = 32'h4d75;
      repeat (10) @(posedge clk);
      rstn <= 1'b1;
      repeat (2) @(posedge clk);
      test_reset_defaults();
      test_immediate();
      test_triggered();
      test_bin_wrap();
      test_memory_and_reset();
      finish_run();
   end

endmodule

// File: all.f
+incdir+.
counter_pkg.sv
input_conditioner.sv
pulse_counter_bank.sv
count_sequencer.sv
bin_ram.sv
counter_regs.sv
photon_counter_top.sv
tb_photon_counter.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_photon_counter \
   -f all.f -o sim_photon_counter && ./obj_dir/sim_photon_counter > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Verification passed" sim.log && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }
